// ==== src/dbg_settings.svh ====
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

// core word and register index widths
`define DBG_WORD_W 32
`define DBG_REG_SEL_W 5

// command bytes from the SPI master
`define DBG_CMD_NOP           8'h00
`define DBG_CMD_ECHO          8'h01
`define DBG_CMD_TOGGLE_LED    8'h02
`define DBG_CMD_ENABLE_CLOCK  8'h03
`define DBG_CMD_DISABLE_CLOCK 8'h04
`define DBG_CMD_STEP_CLOCK    8'h05
`define DBG_CMD_GET_PC        8'h06
`define DBG_CMD_GET_REG       8'h07
`define DBG_CMD_ECHO_CC       8'hCC

// reply to any byte not in the command set
`define DBG_REPLY_ERR 8'hFF

`endif

// ==== src/dbg_pkg.sv ====
`include "dbg_settings.svh"

package dbg_pkg;

    // one byte on the SPI link
    typedef logic [7:0] spi_byte_t;

    // program counter or register value from the core
    typedef logic [`DBG_WORD_W-1:0] core_word_t;

    // core register index for the read port
    typedef logic [`DBG_REG_SEL_W-1:0] reg_sel_t;

    // command unit states
    // idle decodes a fresh command byte
    // echo returns the byte after ECHO
    // read_reg waits for the register index byte
    // replying streams the buffered word out
    typedef enum logic [1:0] {
        DBG_IDLE,
        DBG_ECHO,
        DBG_READ_REG,
        DBG_REPLYING
    } dbg_state_t;

endpackage

// ==== src/spi_slave.sv ====
`timescale 1ns/1ps

module spi_slave (
    input  logic               clk,
    input  logic               rst,
    input  logic               sclk,
    input  logic               mosi,
    input  logic               ss_n,
    output logic               miso,
    input  dbg_pkg::spi_byte_t reply_byte,
    output dbg_pkg::spi_byte_t recv_byte,
    output logic               recv_valid
);

    // two sync stages per pin, third stage of sclk and ss_n for edges
    logic [2:0] sclk_sr;
    logic [1:0] mosi_sr;
    logic [2:0] ss_sr;

    logic sclk_s;
    logic mosi_s;
    logic frame;
    logic sclk_rise;
    logic sclk_fall;
    logic ss_rise;

    // bits received so far in the current byte
    logic [2:0] bit_cnt;

    dbg_pkg::spi_byte_t rx_shift;
    dbg_pkg::spi_byte_t tx_shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_sr <= '0;
            mosi_sr <= '0;
            // slave deselected while in reset
            ss_sr   <= '1;
        end else begin
            sclk_sr <= {sclk_sr[1:0], sclk};
            mosi_sr <= {mosi_sr[0], mosi};
            ss_sr   <= {ss_sr[1:0], ss_n};
        end
    end

    // mosi has the same depth as sclk so it lines up with the edge
    assign sclk_s    = sclk_sr[1];
    assign mosi_s    = mosi_sr[1];
    assign sclk_rise = sclk_sr[1] & ~sclk_sr[2];
    assign sclk_fall = ~sclk_sr[1] & sclk_sr[2];
    assign ss_rise   = ss_sr[1] & ~ss_sr[2];
    assign frame     = ~ss_sr[1];

    // end of frame restarts the byte
    always_ff @(posedge clk) begin
        if (rst || ss_rise) begin
            bit_cnt <= '0;
        end else if (frame && sclk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    // mode 0 receive, msb first on rising sclk
    always_ff @(posedge clk) begin
        if (frame && sclk_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_s};
            if (bit_cnt == 3'd7) begin
                recv_byte <= {rx_shift[6:0], mosi_s};
            end
        end
    end

    // one-cycle strobe on the 8th bit
    always_ff @(posedge clk) begin
        if (rst) begin
            recv_valid <= 1'b0;
        end else begin
            recv_valid <= frame && sclk_rise && (bit_cnt == 3'd7);
        end
    end

    // transmit side
    // between bytes, with sclk low, keep loading the reply so bit 7 is
    // on miso before the first rising edge; the load stops at that edge
    // shift waits for the 8th falling edge so bit 0 holds its full slot
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_shift <= '0;
        end else if ((bit_cnt == 3'd0) && !sclk_s) begin
            tx_shift <= reply_byte;
        end else if (frame && sclk_fall && (bit_cnt != 3'd0)) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign miso = tx_shift[7];

endmodule

// ==== src/dbg_reply_buffer.sv ====
`timescale 1ns/1ps

module dbg_reply_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  dbg_pkg::core_word_t load_word,
    input  logic                pop,
    output dbg_pkg::spi_byte_t  head_byte,
    output logic                last
);

    // bytes per core word, and a count wide enough to hold it
    localparam int NBYTES = $bits(dbg_pkg::core_word_t) / 8;
    localparam int CNT_W  = $clog2(NBYTES + 1);

    // captured word, msb byte sits at the top
    dbg_pkg::core_word_t data;

    // bytes still to hand out
    logic [CNT_W-1:0] count;

    // pop only moves a non-empty buffer
    logic advance;

    assign advance = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= CNT_W'(NBYTES);
        end else if (advance) begin
            count <= count - CNT_W'(1);
        end
    end

    // next byte moves up into the head slot
    always_ff @(posedge clk) begin
        if (load) begin
            data <= load_word;
        end else if (advance) begin
            data <= data << 8;
        end
    end

    assign head_byte = data[$bits(data)-1 -: 8];

    // one byte left
    assign last = (count == CNT_W'(1));

endmodule

// ==== src/dbg_command_unit.sv ====
`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_command_unit (
    input  logic                clk,
    input  logic                rst,
    input  dbg_pkg::spi_byte_t  recv_byte,
    input  logic                recv_valid,
    output dbg_pkg::spi_byte_t  reply_byte,
    output logic                buf_load,
    output dbg_pkg::core_word_t buf_word,
    output logic                buf_pop,
    input  dbg_pkg::spi_byte_t  buf_head,
    input  logic                buf_last,
    input  dbg_pkg::core_word_t core_pc,
    output dbg_pkg::reg_sel_t   reg_sel,
    input  dbg_pkg::core_word_t reg_data,
    output logic                led,
    output logic                core_clk_en
);

    dbg_pkg::dbg_state_t state;

    // level set by the enable and disable commands
    logic clk_en_q;

    // step request, then the one-cycle step pulse behind it
    logic step_req;
    logic step_pulse;

    // reg_sel just changed, reg_data is read on the next edge
    logic reg_pending;

    // GET_PC seen in idle
    logic pc_cmd;

    assign pc_cmd = recv_valid && (state == dbg_pkg::DBG_IDLE)
                    && (recv_byte == `DBG_CMD_GET_PC);

    // pc is captured with the command, register data one cycle after reg_sel
    assign buf_load = pc_cmd || reg_pending;
    assign buf_word = reg_pending ? reg_data : core_pc;

    // each byte received while replying takes the next buffered byte
    assign buf_pop = recv_valid && (state == dbg_pkg::DBG_REPLYING);

    // step pulse adds one cycle to a stopped clock
    assign core_clk_en = clk_en_q || step_pulse;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= dbg_pkg::DBG_IDLE;
            reply_byte  <= '0;
            led         <= 1'b0;
            // core clock runs by default
            clk_en_q    <= 1'b1;
            step_req    <= 1'b0;
            step_pulse  <= 1'b0;
            reg_sel     <= '0;
            reg_pending <= 1'b0;
        end else begin
            // pulse lands two cycles after recv_valid
            step_pulse  <= step_req;
            step_req    <= 1'b0;
            reg_pending <= 1'b0;

            // register word is in the buffer, start streaming it
            if (reg_pending) begin
                state <= dbg_pkg::DBG_REPLYING;
            end

            if (recv_valid) begin
                case (state)
                    dbg_pkg::DBG_IDLE: begin
                        case (recv_byte)
                            `DBG_CMD_NOP: begin
                                reply_byte <= 8'h00;
                            end
                            `DBG_CMD_ECHO: begin
                                reply_byte <= `DBG_CMD_ECHO;
                                state      <= dbg_pkg::DBG_ECHO;
                            end
                            `DBG_CMD_TOGGLE_LED: begin
                                reply_byte <= 8'h00;
                                led        <= ~led;
                            end
                            `DBG_CMD_ENABLE_CLOCK: begin
                                reply_byte <= 8'h00;
                                clk_en_q   <= 1'b1;
                            end
                            `DBG_CMD_DISABLE_CLOCK: begin
                                reply_byte <= 8'h00;
                                clk_en_q   <= 1'b0;
                            end
                            `DBG_CMD_STEP_CLOCK: begin
                                reply_byte <= 8'h00;
                                // no effect on a running clock
                                step_req   <= ~clk_en_q;
                            end
                            `DBG_CMD_GET_PC: begin
                                reply_byte <= 8'h00;
                                state      <= dbg_pkg::DBG_REPLYING;
                            end
                            `DBG_CMD_GET_REG: begin
                                reply_byte <= 8'h00;
                                state      <= dbg_pkg::DBG_READ_REG;
                            end
                            `DBG_CMD_ECHO_CC: begin
                                reply_byte <= `DBG_CMD_ECHO_CC;
                            end
                            default: begin
                                reply_byte <= `DBG_REPLY_ERR;
                            end
                        endcase
                    end
                    dbg_pkg::DBG_ECHO: begin
                        reply_byte <= recv_byte;
                        state      <= dbg_pkg::DBG_IDLE;
                    end
                    dbg_pkg::DBG_READ_REG: begin
                        // low bits of the operand pick the register
                        reply_byte  <= 8'h00;
                        reg_sel     <= recv_byte[`DBG_REG_SEL_W-1:0];
                        reg_pending <= 1'b1;
                    end
                    dbg_pkg::DBG_REPLYING: begin
                        // received byte is ignored here
                        reply_byte <= buf_head;
                        if (buf_last) begin
                            state <= dbg_pkg::DBG_IDLE;
                        end
                    end
                    default: begin
                        state <= dbg_pkg::DBG_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// ==== src/dbg_spi_top.sv ====
`timescale 1ns/1ps

module dbg_spi_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                sclk,
    input  logic                mosi,
    input  logic                ss_n,
    output logic                miso,
    input  dbg_pkg::core_word_t core_pc,
    output dbg_pkg::reg_sel_t   reg_sel,
    input  dbg_pkg::core_word_t reg_data,
    output logic                led,
    output logic                core_clk_en
);

    // receiver to command unit
    dbg_pkg::spi_byte_t recv_byte;
    logic               recv_valid;

    // held reply for the next exchange
    dbg_pkg::spi_byte_t reply_byte;

    // command unit to reply buffer
    logic                buf_load;
    dbg_pkg::core_word_t buf_word;
    logic                buf_pop;
    dbg_pkg::spi_byte_t  buf_head;
    logic                buf_last;

    spi_slave u_spi (
        .clk        (clk),
        .rst        (rst),
        .sclk       (sclk),
        .mosi       (mosi),
        .ss_n       (ss_n),
        .miso       (miso),
        .reply_byte (reply_byte),
        .recv_byte  (recv_byte),
        .recv_valid (recv_valid)
    );

    dbg_reply_buffer u_buf (
        .clk       (clk),
        .rst       (rst),
        .load      (buf_load),
        .load_word (buf_word),
        .pop       (buf_pop),
        .head_byte (buf_head),
        .last      (buf_last)
    );

    dbg_command_unit u_cmd (
        .clk         (clk),
        .rst         (rst),
        .recv_byte   (recv_byte),
        .recv_valid  (recv_valid),
        .reply_byte  (reply_byte),
        .buf_load    (buf_load),
        .buf_word    (buf_word),
        .buf_pop     (buf_pop),
        .buf_head    (buf_head),
        .buf_last    (buf_last),
        .core_pc     (core_pc),
        .reg_sel     (reg_sel),
        .reg_data    (reg_data),
        .led         (led),
        .core_clk_en (core_clk_en)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reset held for 16 rising edges
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== tb/dbg_checker.sv ====
`timescale 1ns/1ps

module dbg_checker (
    input logic                clk,
    input logic                rst,
    input logic                recv_valid,
    input logic                step_pulse,
    input logic                buf_load,
    input dbg_pkg::dbg_state_t state
);

    // failure counts per property
    int fail_rv = 0;
    int fail_step = 0;
    int fail_load = 0;
    int fail_cnt;

    assign fail_cnt = fail_rv + fail_step + fail_load;

    // one strobe per received byte
    a_recv_single: assert property (@(posedge clk) disable iff (rst)
        recv_valid |=> !recv_valid)
        else begin
            $error("recv_valid high in two consecutive cycles");
            fail_rv++;
        end

    // single step is exactly one core clock
    a_step_single: assert property (@(posedge clk) disable iff (rst)
        step_pulse |=> !step_pulse)
        else begin
            $error("step pulse longer than one cycle");
            fail_step++;
        end

    // a word is streamed only from a freshly filled buffer
    a_reply_after_load: assert property (@(posedge clk) disable iff (rst)
        (state == dbg_pkg::DBG_REPLYING) && ($past(state) != dbg_pkg::DBG_REPLYING)
        |-> $past(buf_load))
        else begin
            $error("replying state entered without a buffer load");
            fail_load++;
        end

endmodule

bind dbg_command_unit dbg_checker u_chk (
    .clk        (clk),
    .rst        (rst),
    .recv_valid (recv_valid),
    .step_pulse (step_pulse),
    .buf_load   (buf_load),
    .state      (state)
);

// ==== tb/tb_dbg_monitor.sv ====
`timescale 1ns/1ps
`include "dbg_settings.svh"

module tb_dbg_monitor (
    input  logic                clk,
    input  logic                rst,
    input  logic                sclk,
    input  logic                mosi,
    input  logic                ss_n,
    input  logic                miso,
    input  logic                led,
    input  logic                core_clk_en,
    input  dbg_pkg::reg_sel_t   reg_sel,
    input  dbg_pkg::core_word_t core_pc,
    input  dbg_pkg::core_word_t reg_table [32],
    input  int                  assert_fails,
    input  logic                done,
    output int                  err_count,
    output logic                finished
);

    // model state 0 idle, 1 echo, 2 register index, 3 streaming a word
    int                  mode = 0;
    dbg_pkg::core_word_t word = '0;
    int                  left = 0;
    string               word_name = "";
    dbg_pkg::spi_byte_t  exp_reply = 8'h00;
    string               exp_name = "reset_reply";
    logic                led_m = 1'b0;
    logic                en_m = 1'b1;
    logic                en_ck = 1'b1;
    logic                step_pend = 1'b0;
    dbg_pkg::reg_sel_t   sel_m = '0;

    int                 bit_n = 0;
    dbg_pkg::spi_byte_t mo_sr = '0;
    dbg_pkg::spi_byte_t mi_sr = '0;
    int                 n_bytes = 0;
    int                 reply_errs = 0;
    int                 level_errs = 0;

    // core clock high cycles, and the mark at the last level check
    int highs_total = 0;
    int highs_mark = 0;

    always @(posedge clk) begin
        if (core_clk_en === 1'b1) begin
            highs_total++;
        end
    end

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %s expected %h actual %h", name, exp, act);
    endtask

    // effects of the previous byte have settled by now
    task automatic check_levels();
        if (led !== led_m) begin
            report("led_level", 32'(led_m), 32'(led));
            level_errs++;
        end
        if (core_clk_en !== en_m) begin
            report("core_clk_en_level", 32'(en_m), 32'(core_clk_en));
            level_errs++;
        end
        if (reg_sel !== sel_m) begin
            report("reg_sel", 32'(sel_m), 32'(reg_sel));
            level_errs++;
        end
        // step cycles counted while the clock was stopped on both sides of the window
        if (!en_m && !en_ck && (highs_total - highs_mark) != (step_pend ? 1 : 0)) begin
            report("step_pulse_cycles", step_pend ? 1 : 0, highs_total - highs_mark);
            level_errs++;
        end
        highs_mark = highs_total;
        step_pend  = 1'b0;
        en_ck      = en_m;
    endtask

    // reply rules, one received byte at a time
    task automatic model_byte(input dbg_pkg::spi_byte_t b);
        case (mode)
            0: begin
                exp_reply = 8'h00;
                case (b)
                    `DBG_CMD_NOP: exp_name = "nop_reply";
                    `DBG_CMD_ECHO: begin
                        exp_reply = 8'h01;
                        exp_name  = "echo_cmd_reply";
                        mode      = 1;
                    end
                    `DBG_CMD_TOGGLE_LED: begin
                        exp_name = "toggle_led_reply";
                        led_m    = ~led_m;
                    end
                    `DBG_CMD_ENABLE_CLOCK: begin
                        exp_name = "enable_clock_reply";
                        en_m     = 1'b1;
                    end
                    `DBG_CMD_DISABLE_CLOCK: begin
                        exp_name = "disable_clock_reply";
                        en_m     = 1'b0;
                    end
                    `DBG_CMD_STEP_CLOCK: begin
                        exp_name  = "step_clock_reply";
                        step_pend = !en_m;
                    end
                    `DBG_CMD_GET_PC: begin
                        exp_name  = "get_pc_reply";
                        word      = core_pc;
                        word_name = "get_pc_word";
                        left      = 4;
                        mode      = 3;
                    end
                    `DBG_CMD_GET_REG: begin
                        exp_name = "get_reg_reply";
                        mode     = 2;
                    end
                    `DBG_CMD_ECHO_CC: begin
                        exp_reply = 8'hCC;
                        exp_name  = "echo_cc_reply";
                    end
                    default: begin
                        exp_reply = 8'hFF;
                        exp_name  = "unknown_reply";
                    end
                endcase
            end
            1: begin
                exp_reply = b;
                exp_name  = "echo_data_reply";
                mode      = 0;
            end
            2: begin
                exp_reply = 8'h00;
                exp_name  = "get_reg_index_reply";
                sel_m     = b[4:0];
                word      = reg_table[b[4:0]];
                word_name = "get_reg_word";
                left      = 4;
                mode      = 3;
            end
            default: begin
                // operand bytes are ignored while the word goes out
                exp_reply = word[31:24];
                exp_name  = word_name;
                word      = word << 8;
                left--;
                if (left == 0) begin
                    mode = 0;
                end
            end
        endcase
    endtask

    always @(posedge sclk or posedge done) begin
        if (done) begin
            if (finished !== 1'b1) begin
                check_levels();
                err_count = reply_errs + level_errs + assert_fails;
                $display("monitor: %0d bytes, errors %0d reply, %0d level, %0d assertion",
                         n_bytes, reply_errs, level_errs, assert_fails);
                finished = 1'b1;
            end
        end else if (!ss_n && !rst) begin
            if (bit_n == 0) begin
                check_levels();
            end
            // both lines are stable at the rising sclk edge
            mo_sr = {mo_sr[6:0], mosi};
            mi_sr = {mi_sr[6:0], miso};
            bit_n++;
            if (bit_n == 8) begin
                bit_n = 0;
                n_bytes++;
                if (mi_sr !== exp_reply) begin
                    report(exp_name, 32'(exp_reply), 32'(mi_sr));
                    reply_errs++;
                end
                model_byte(mo_sr);
            end
        end
    end

endmodule

// ==== tb/tb_dbg_top.sv ====
`timescale 1ns/1ps
`include "dbg_settings.svh"

module tb_dbg_top;

    // sclk half period and inter-byte gap, in clk cycles
    localparam int HALF       = 6;
    localparam int GAP        = 12;
    localparam int WAIT_LIMIT = 2000;

    logic clk;
    logic rst;
    logic sclk;
    logic mosi;
    logic ss_n;
    logic miso;
    logic led;
    logic core_clk_en;
    logic done;
    logic finished;

    dbg_pkg::core_word_t core_pc;
    dbg_pkg::core_word_t reg_data;
    dbg_pkg::reg_sel_t   reg_sel;
    dbg_pkg::core_word_t reg_table [32];

    integer seed;
    int     bytes_sent;
    int     bytes_taken = 0;
    int     err_count;
    string  stall_note;
    event   stall_ev;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    dbg_spi_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .sclk        (sclk),
        .mosi        (mosi),
        .ss_n        (ss_n),
        .miso        (miso),
        .core_pc     (core_pc),
        .reg_sel     (reg_sel),
        .reg_data    (reg_data),
        .led         (led),
        .core_clk_en (core_clk_en)
    );

    tb_dbg_monitor u_mon (
        .clk          (clk),
        .rst          (rst),
        .sclk         (sclk),
        .mosi         (mosi),
        .ss_n         (ss_n),
        .miso         (miso),
        .led          (led),
        .core_clk_en  (core_clk_en),
        .reg_sel      (reg_sel),
        .core_pc      (core_pc),
        .reg_table    (reg_table),
        .assert_fails (u_dut.u_cmd.u_chk.fail_cnt),
        .done         (done),
        .err_count    (err_count),
        .finished     (finished)
    );

    // core register file read port, combinational like the core's
    assign reg_data = reg_table[reg_sel];

    // bytes the receiver has strobed into the command unit
    always @(posedge clk) begin
        if (u_dut.recv_valid) begin
            bytes_taken <= bytes_taken + 1;
        end
    end

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    function automatic logic is_cmd(input dbg_pkg::spi_byte_t b);
        is_cmd = b inside {`DBG_CMD_NOP, `DBG_CMD_ECHO, `DBG_CMD_TOGGLE_LED,
                           `DBG_CMD_ENABLE_CLOCK, `DBG_CMD_DISABLE_CLOCK,
                           `DBG_CMD_STEP_CLOCK, `DBG_CMD_GET_PC, `DBG_CMD_GET_REG,
                           `DBG_CMD_ECHO_CC};
    endfunction

    // a stalled step ends the run from its own process
    initial begin
        @(stall_ev);
        $display("%s", stall_note);
        $display("TEST FAILED");
        $finish;
    end

    task automatic wait_reset_done();
        int t;
        t = 0;
        while (rst !== 1'b0 && t < WAIT_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (rst !== 1'b0) begin
            stall_note = "timeout: reset never released";
            -> stall_ev;
        end
    endtask

    // mode 0, msb first; mosi set while sclk is low
    task automatic send_byte(input dbg_pkg::spi_byte_t b);
        int t;
        for (int i = 7; i >= 0; i--) begin
            mosi <= b[i];
            repeat (HALF) @(posedge clk);
            sclk <= 1'b1;
            repeat (HALF) @(posedge clk);
            sclk <= 1'b0;
        end
        bytes_sent++;
        t = 0;
        while (bytes_taken < bytes_sent && t < WAIT_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (bytes_taken < bytes_sent) begin
            stall_note = $sformatf("timeout: DUT never received byte %0d", bytes_sent);
            -> stall_ev;
        end
        repeat (GAP) @(posedge clk);
    endtask

    task automatic start_frame();
        ss_n <= 1'b0;
        repeat (GAP) @(posedge clk);
    endtask

    // pc only moves while the slave is deselected
    task automatic end_frame();
        ss_n <= 1'b1;
        repeat (GAP) @(posedge clk);
        core_pc <= rand32();
        repeat (GAP) @(posedge clk);
    endtask

    // command plus whatever operand or filler bytes it takes
    task automatic send_cmd(input dbg_pkg::spi_byte_t c);
        send_byte(c);
        if (c == `DBG_CMD_ECHO) begin
            send_byte(8'(rand32()));
        end else if (c == `DBG_CMD_GET_PC) begin
            repeat (4) send_byte(8'(rand32()));
        end else if (c == `DBG_CMD_GET_REG) begin
            send_byte(8'(rand32()));
            repeat (4) send_byte(8'(rand32()));
        end
    endtask

    function automatic dbg_pkg::spi_byte_t pick_cmd();
        dbg_pkg::spi_byte_t b;
        case (rand32() % 12)
            0: b = `DBG_CMD_NOP;
            1: b = `DBG_CMD_ECHO;
            2: b = `DBG_CMD_TOGGLE_LED;
            3: b = `DBG_CMD_ENABLE_CLOCK;
            4: b = `DBG_CMD_DISABLE_CLOCK;
            5: b = `DBG_CMD_STEP_CLOCK;
            6: b = `DBG_CMD_GET_PC;
            7: b = `DBG_CMD_GET_REG;
            8: b = `DBG_CMD_ECHO_CC;
            9: b = `DBG_CMD_STEP_CLOCK;
            default: begin
                // unknown byte
                b = 8'(rand32());
                while (is_cmd(b)) begin
                    b = 8'(rand32());
                end
            end
        endcase
        return b;
    endfunction

    initial begin
        int n;
        seed       = 32'hf1ee_6a21;
        bytes_sent = 0;
        sclk    <= 1'b0;
        mosi    <= 1'b0;
        ss_n    <= 1'b1;
        done    <= 1'b0;
        core_pc <= 32'h0000_1000;
        for (int i = 0; i < 32; i++) begin
            reg_table[i] = rand32();
        end
        wait_reset_done();
        @(posedge clk);

        // directed burst over every command first
        start_frame();
        send_cmd(`DBG_CMD_NOP);
        send_cmd(`DBG_CMD_ECHO_CC);
        send_cmd(8'h5A);
        send_cmd(`DBG_CMD_ECHO);
        send_cmd(`DBG_CMD_TOGGLE_LED);
        send_cmd(`DBG_CMD_DISABLE_CLOCK);
        send_cmd(`DBG_CMD_STEP_CLOCK);
        send_cmd(`DBG_CMD_STEP_CLOCK);
        send_cmd(`DBG_CMD_ENABLE_CLOCK);
        send_cmd(`DBG_CMD_STEP_CLOCK);
        send_cmd(`DBG_CMD_GET_PC);
        send_cmd(`DBG_CMD_GET_REG);
        send_cmd(`DBG_CMD_TOGGLE_LED);
        end_frame();

        repeat (40) begin
            start_frame();
            n = 1 + int'(rand32() % 6);
            repeat (n) send_cmd(pick_cmd());
            end_frame();
        end

        done <= 1'b1;
        n = 0;
        while (finished !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (finished !== 1'b1) begin
            stall_note = "timeout: monitor never closed the run";
            -> stall_ev;
        end else if (err_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+src
src/dbg_pkg.sv
src/spi_slave.sv
src/dbg_reply_buffer.sv
src/dbg_command_unit.sv
src/dbg_spi_top.sv
tb/tb_clock_gen.sv
tb/dbg_checker.sv
tb/tb_dbg_monitor.sv
tb/tb_dbg_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the SPI debug port testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_dbg_top \
    -f sources.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
